// ==== Bender.yml ====
package:
  name: prc

sources:
  - prc_pkg.sv
  - prc_regs.sv
  - prc_frame_timer.sv
  - prc_stage_ctrl.sv
  - prc_map_renderer.sv
  - prc_frame_copier.sv
  - prc.sv
  - target: test
    files:
      - tb_prc.sv

// ==== prc.sv ====
module prc
(
    input  logic           clk,
    input  logic           reset,
    input  prc_pkg::addr_t reg_address,
    input  prc_pkg::byte_t reg_wdata,
    input  logic           reg_write,
    input  logic           reg_read,
    input  prc_pkg::byte_t mem_rdata,
    input  logic           mem_grant,
    output prc_pkg::byte_t reg_rdata,
    output prc_pkg::addr_t mem_address,
    output prc_pkg::byte_t mem_wdata,
    output logic           mem_read,
    output logic           mem_write,
    output logic           mem_request,
    output logic           irq_copy_complete,
    output logic           irq_render_done
);
    import prc_pkg::*;

    logic [5:0] mode;
    addr_t      map_base;
    logic [6:0] scroll_x;
    logic [6:0] scroll_y;
    logic [4:0] map_width;
    logic [6:0] frame_count;
    logic       frame_start;
    logic       render_window;
    logic       tick;
    stage_t     stage;
    logic       map_start;
    logic       copy_start;
    logic       map_grant;
    logic       copy_grant;
    logic       map_done;
    logic       copy_done;
    addr_t      map_address;
    addr_t      copy_address;
    byte_t      map_wdata;
    byte_t      copy_wdata;
    logic       map_read;
    logic       map_write;
    logic       copy_read;
    logic       copy_write;
    logic       copy_sel;

    // Register reads have no side effects, so reg_read is left open
    prc_regs u_regs (.*, .map_height());

    prc_frame_timer u_timer (.*);

    prc_stage_ctrl u_ctrl (.*);

    prc_map_renderer u_map
    (
        .*,
        .start       (map_start),
        .grant       (map_grant),
        .done        (map_done),
        .mem_address (map_address),
        .mem_wdata   (map_wdata),
        .mem_read    (map_read),
        .mem_write   (map_write)
    );

    prc_frame_copier u_copy
    (
        .*,
        .start       (copy_start),
        .grant       (copy_grant),
        .done        (copy_done),
        .mem_address (copy_address),
        .mem_wdata   (copy_wdata),
        .mem_read    (copy_read),
        .mem_write   (copy_write)
    );

    // Idle engines keep their strobes low
    assign copy_sel    = (stage == STAGE_COPY);
    assign mem_address = copy_sel ? copy_address : map_address;
    assign mem_wdata   = copy_sel ? copy_wdata : map_wdata;
    assign mem_read    = copy_sel ? copy_read : map_read;
    assign mem_write   = copy_sel ? copy_write : map_write;

endmodule

// ==== prc_frame_copier.sv ====
module prc_frame_copier
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           grant,
    input  prc_pkg::byte_t mem_rdata,
    output logic           done,
    output prc_pkg::addr_t mem_address,
    output prc_pkg::byte_t mem_wdata,
    output logic           mem_read,
    output logic           mem_write
);
    import prc_pkg::*;

    logic       busy;
    logic       strobe_phase;
    copy_step_t step;
    logic [6:0] col;
    logic [2:0] page;
    logic       access_go;
    logic       last_col;
    addr_t      next_address;

    assign access_go = busy && grant;
    assign last_col  = (col == 7'(SCREEN_W - 1));

    always_comb
    begin
        case (step)
            COPY_READ:  next_address = FB_BASE + addr_t'(page) * addr_t'(SCREEN_W) + addr_t'(col);
            COPY_WRITE: next_address = LCD_DATA_ADDR;
            default:    next_address = LCD_CMD_ADDR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (access_go && !strobe_phase)
            mem_address <= next_address;
        if (access_go && strobe_phase)
        begin
            case (step)
                COPY_COL_HI: mem_wdata <= LCD_COL_HI_CMD;
                COPY_COL_LO: mem_wdata <= LCD_COL_LO_CMD;
                COPY_PAGE:   mem_wdata <= LCD_PAGE_CMD | {5'b0, page};
                default:     mem_wdata <= mem_rdata;    // Byte from the frame-buffer read
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        done      <= 1'b0;
        if (reset)
        begin
            busy         <= 1'b0;
            strobe_phase <= 1'b0;
            step         <= COPY_COL_HI;
            col          <= '0;
            page         <= '0;
        end
        else if (start && !busy)
        begin
            busy         <= 1'b1;
            strobe_phase <= 1'b0;
            step         <= COPY_COL_HI;
            col          <= '0;
            page         <= '0;
        end
        else if (access_go)
        begin
            strobe_phase <= ~strobe_phase;
            if (strobe_phase)
            begin
                mem_read  <= (step == COPY_READ);
                mem_write <= (step != COPY_READ);
                case (step)
                    COPY_COL_HI: step <= COPY_COL_LO;
                    COPY_COL_LO: step <= COPY_PAGE;
                    COPY_PAGE:   step <= COPY_READ;
                    COPY_READ:   step <= COPY_WRITE;
                    default:
                    begin
                        col  <= last_col ? 7'd0 : col + 7'd1;
                        step <= last_col ? COPY_COL_HI : COPY_READ;  // New page after column 95
                        if (last_col)
                        begin
                            page <= page + 3'd1;
                            if (page == 3'(SCREEN_PAGES - 1))
                            begin
                                busy <= 1'b0;
                                done <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== prc_frame_timer.sv ====
module prc_frame_timer
(
    input  logic       clk,
    input  logic       reset,
    output logic [6:0] frame_count,
    output logic       frame_start,
    output logic       render_window,
    output logic       irq_render_done,
    output logic       tick
);
    import prc_pkg::*;

    logic [9:0] tick_div;
    logic [6:0] count_next;

    assign tick       = (tick_div == 10'(TICK_CYCLES - 1));
    assign count_next = (frame_count == COUNT_WINDOW_END) ? 7'd1 : frame_count + 7'd1;

    always_ff @(posedge clk)
    begin
        frame_start <= 1'b0;
        if (reset)
        begin
            tick_div        <= '0;
            frame_count     <= 7'd1;
            render_window   <= 1'b0;
            irq_render_done <= 1'b0;
        end
        else if (tick)
        begin
            tick_div        <= '0;
            frame_count     <= count_next;
            frame_start     <= (count_next == COUNT_WINDOW_OPEN);
            irq_render_done <= (count_next == COUNT_WINDOW_END);  // Held for one tick

            if (count_next == COUNT_WINDOW_OPEN)
                render_window <= 1'b1;
            else if (count_next == COUNT_WINDOW_END)
                render_window <= 1'b0;
        end
        else
        begin
            tick_div <= tick_div + 10'd1;
        end
    end

endmodule

// ==== prc_map_renderer.sv ====
module prc_map_renderer
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           grant,
    input  prc_pkg::addr_t map_base,
    input  logic [6:0]     scroll_x,
    input  logic [6:0]     scroll_y,
    input  logic [4:0]     map_width,
    input  prc_pkg::byte_t mem_rdata,
    output logic           done,
    output prc_pkg::addr_t mem_address,
    output prc_pkg::byte_t mem_wdata,
    output logic           mem_read,
    output logic           mem_write
);
    import prc_pkg::*;

    logic       busy;
    logic       strobe_phase;     // Low in the address cycle, high in the strobe cycle
    logic [2:0] step;             // Access 0 to 4 of the current column
    logic [6:0] col;
    logic [2:0] page;
    logic       access_go;
    logic       last_col;
    logic [7:0] map_x;
    logic [7:0] map_y;
    byte_t      tile_index;
    byte_t      tile_top;
    byte_t      column_byte;
    addr_t      next_address;

    assign access_go = busy && grant;
    assign last_col  = (col == 7'(SCREEN_W - 1));
    assign map_x     = {1'b0, col} + {1'b0, scroll_x};
    assign map_y     = {2'b0, page, 3'b0} + {1'b0, scroll_y};

    // Bottom tile byte arrives on mem_rdata during the write access
    assign column_byte = (tile_top >> map_y[2:0])
                       | (mem_rdata << (4'd8 - {1'b0, map_y[2:0]}));

    always_comb
    begin
        case (step)
            3'd0:    next_address = TILE_MAP_BASE + addr_t'(map_y[7:3]) * addr_t'(map_width)
                                    + addr_t'(map_x[7:3]);
            3'd1:    next_address = mem_address + addr_t'(map_width);  // One map row below
            3'd2,
            3'd3:    next_address = map_base + {13'd0, tile_index, map_x[2:0]};
            default: next_address = FB_BASE + addr_t'(page) * addr_t'(SCREEN_W) + addr_t'(col);
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (access_go && !strobe_phase)
            mem_address <= next_address;
        if (access_go && strobe_phase)
        begin
            if (step == 3'd1 || step == 3'd2)
                tile_index <= mem_rdata;              // Top index, then bottom index
            if (step == 3'd3)
                tile_top <= mem_rdata;
            if (step == 3'd4)
                mem_wdata <= column_byte;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        done      <= 1'b0;
        if (reset)
        begin
            busy         <= 1'b0;
            strobe_phase <= 1'b0;
            step         <= '0;
            col          <= '0;
            page         <= '0;
        end
        else if (start && !busy)
        begin
            busy         <= 1'b1;
            strobe_phase <= 1'b0;
            step         <= '0;
            col          <= '0;
            page         <= '0;
        end
        else if (access_go)
        begin
            strobe_phase <= ~strobe_phase;
            if (strobe_phase)
            begin
                mem_read  <= (step != 3'd4);
                mem_write <= (step == 3'd4);
                step      <= (step == 3'd4) ? 3'd0 : step + 3'd1;
                if (step == 3'd4)
                begin
                    col <= last_col ? 7'd0 : col + 7'd1;
                    if (last_col)
                    begin
                        page <= page + 3'd1;
                        if (page == 3'(SCREEN_PAGES - 1))
                        begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== prc_pkg.sv ====
package prc_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [7:0]  byte_t;

    typedef enum logic [1:0]
    {
        STAGE_IDLE,
        STAGE_MAP,
        STAGE_COPY
    } stage_t;

    // Frame copier access sequence
    typedef enum logic [2:0]
    {
        COPY_COL_HI,
        COPY_COL_LO,
        COPY_PAGE,
        COPY_READ,
        COPY_WRITE
    } copy_step_t;

    localparam addr_t FB_BASE       = 24'h001000;
    localparam addr_t TILE_MAP_BASE = 24'h001360;
    localparam addr_t LCD_CMD_ADDR  = 24'h0020FE;
    localparam addr_t LCD_DATA_ADDR = 24'h0020FF;
    localparam addr_t REG_BASE      = 24'h002080;

    // Register offsets from REG_BASE
    localparam logic [3:0] REG_MODE     = 4'h0;
    localparam logic [3:0] REG_RATE     = 4'h1;
    localparam logic [3:0] REG_MAP_LO   = 4'h2;
    localparam logic [3:0] REG_MAP_MID  = 4'h3;
    localparam logic [3:0] REG_MAP_HI   = 4'h4;
    localparam logic [3:0] REG_SCROLL_Y = 4'h5;
    localparam logic [3:0] REG_SCROLL_X = 4'h6;
    localparam logic [3:0] REG_COUNTER  = 4'hA;

    localparam int SCREEN_W     = 96;
    localparam int SCREEN_PAGES = 8;
    localparam int TICK_CYCLES  = 855;   // Clocks per oscillator tick

    localparam logic [6:0] COUNT_WINDOW_OPEN = 7'h18;
    localparam logic [6:0] COUNT_WINDOW_END  = 7'h41;

    localparam int MODE_MAP_BIT  = 1;
    localparam int MODE_COPY_BIT = 3;
    localparam int MODE_SIZE_LSB = 4;

    localparam byte_t LCD_COL_HI_CMD = 8'h10;
    localparam byte_t LCD_COL_LO_CMD = 8'h00;
    localparam byte_t LCD_PAGE_CMD   = 8'hB0;

endpackage

// ==== prc_regs.sv ====
module prc_regs
(
    input  logic           clk,
    input  logic           reset,
    input  prc_pkg::addr_t reg_address,
    input  prc_pkg::byte_t reg_wdata,
    input  logic           reg_write,
    input  logic [6:0]     frame_count,
    output prc_pkg::byte_t reg_rdata,
    output logic [5:0]     mode,
    output prc_pkg::addr_t map_base,
    output logic [6:0]     scroll_x,
    output logic [6:0]     scroll_y,
    output logic [4:0]     map_width,
    output logic [4:0]     map_height
);
    import prc_pkg::*;

    logic       reg_hit;
    logic [3:0] reg_offset;
    logic [7:0] scroll_x_max;
    logic [7:0] scroll_y_max;

    assign reg_hit      = (reg_address[23:4] == REG_BASE[23:4]);
    assign reg_offset   = reg_address[3:0];
    assign scroll_x_max = {map_width, 3'b0} - 8'd96;    // Map pixels beyond the screen
    assign scroll_y_max = {map_height, 3'b0} - 8'd64;

    // Map size in tiles as width then height
    always_comb
    begin
        case (mode[MODE_SIZE_LSB +: 2])
            2'd0:    {map_width, map_height} = {5'd12, 5'd16};
            2'd1:    {map_width, map_height} = {5'd16, 5'd12};
            2'd2:    {map_width, map_height} = {5'd24, 5'd8};
            default: {map_width, map_height} = {5'd24, 5'd16};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mode     <= '0;
            map_base <= '0;
            scroll_x <= '0;
            scroll_y <= '0;
        end
        else if (reg_write && reg_hit)
        begin
            case (reg_offset)
                REG_MODE:     mode            <= reg_wdata[5:0];
                REG_MAP_LO:   map_base[7:3]   <= reg_wdata[7:3];  // Tile base is 8-byte aligned
                REG_MAP_MID:  map_base[15:8]  <= reg_wdata;
                REG_MAP_HI:   map_base[20:16] <= reg_wdata[4:0];
                REG_SCROLL_Y:
                    if (reg_wdata <= scroll_y_max)
                        scroll_y <= reg_wdata[6:0];
                REG_SCROLL_X:
                    if (reg_wdata <= scroll_x_max)
                        scroll_x <= reg_wdata[6:0];
                default:
                begin
                end
            endcase
        end
    end

    always_comb
    begin
        reg_rdata = '0;
        if (reg_hit)
        begin
            case (reg_offset)
                REG_MODE:     reg_rdata = {2'b0, mode};
                REG_RATE:     reg_rdata = '0;         // Every frame is active
                REG_MAP_LO:   reg_rdata = map_base[7:0];
                REG_MAP_MID:  reg_rdata = map_base[15:8];
                REG_MAP_HI:   reg_rdata = map_base[23:16];
                REG_SCROLL_Y: reg_rdata = {1'b0, scroll_y};
                REG_SCROLL_X: reg_rdata = {1'b0, scroll_x};
                REG_COUNTER:  reg_rdata = {1'b0, frame_count};
                default:      reg_rdata = '0;
            endcase
        end
    end

endmodule

// ==== prc_stage_ctrl.sv ====
module prc_stage_ctrl
(
    input  logic            clk,
    input  logic            reset,
    input  logic [5:0]      mode,
    input  logic            frame_start,
    input  logic            render_window,
    input  logic            tick,
    input  logic            mem_grant,
    input  logic            map_done,
    input  logic            copy_done,
    output prc_pkg::stage_t stage,
    output logic            map_start,
    output logic            copy_start,
    output logic            map_grant,
    output logic            copy_grant,
    output logic            mem_request,
    output logic            irq_copy_complete
);
    import prc_pkg::*;

    // Only the running engine sees the bus grant
    assign map_grant   = (stage == STAGE_MAP) && mem_grant;
    assign copy_grant  = (stage == STAGE_COPY) && mem_grant;
    assign mem_request = (stage != STAGE_IDLE);

    always_ff @(posedge clk)
    begin
        map_start  <= 1'b0;
        copy_start <= 1'b0;
        if (reset)
        begin
            stage             <= STAGE_IDLE;
            irq_copy_complete <= 1'b0;
        end
        else
        begin
            if (tick)
                irq_copy_complete <= 1'b0;

            case (stage)
                STAGE_IDLE:
                    if (frame_start)
                    begin
                        if (mode[MODE_MAP_BIT])
                        begin
                            stage     <= STAGE_MAP;
                            map_start <= 1'b1;
                        end
                        else if (mode[MODE_COPY_BIT])
                        begin
                            stage      <= STAGE_COPY;
                            copy_start <= 1'b1;
                        end
                    end
                STAGE_MAP:
                    if (map_done)
                    begin
                        // No copy is started once the window has closed
                        stage      <= (mode[MODE_COPY_BIT] && render_window) ? STAGE_COPY
                                                                            : STAGE_IDLE;
                        copy_start <= mode[MODE_COPY_BIT] && render_window;
                    end
                default:
                    if (copy_done)
                    begin
                        stage             <= STAGE_IDLE;
                        irq_copy_complete <= 1'b1;   // Wins over a clearing tick
                    end
            endcase
        end
    end

endmodule

// ==== src.f ====
prc_pkg.sv
prc_regs.sv
prc_frame_timer.sv
prc_stage_ctrl.sv
prc_map_renderer.sv
prc_frame_copier.sv
prc.sv
tb_prc.sv

// ==== tb_prc.sv ====
module tb_prc;
    timeunit 1ns;
    timeprecision 100ps;

    import prc_pkg::*;

    localparam int      CLK_PERIOD   = 40;
    localparam int      DRIVE_DELAY  = 2;
    localparam int      RESET_CYCLES = 10;
    localparam int      FRAME_CYCLES = 65 * TICK_CYCLES;     // 65 ticks per frame
    localparam int      FB_BYTES     = SCREEN_W * SCREEN_PAGES;
    localparam longint  WATCHDOG_NS  = 4 * FRAME_CYCLES * CLK_PERIOD;
    localparam int      SEED         = 32'he655;

    logic  clk;
    logic  reset;
    addr_t reg_address;
    byte_t reg_wdata;
    logic  reg_write;
    logic  reg_read;
    byte_t mem_rdata;
    logic  mem_grant;
    byte_t reg_rdata;
    addr_t mem_address;
    byte_t mem_wdata;
    logic  mem_read;
    logic  mem_write;
    logic  mem_request;
    logic  irq_copy_complete;
    logic  irq_render_done;

    byte_t mem [0:65535];
    byte_t exp_fb [0:FB_BYTES-1];
    int    lcd_log [$];              // {is_data, byte} per LCD port write
    string test_name;
    int    test_errors;
    int    pass_count;
    int    fail_count;

    prc dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // System memory with one cycle of read latency and an LCD write log
    always @(posedge clk)
    begin
        byte_t read_byte;
        logic  read_pending;
        read_pending = mem_read;
        read_byte    = mem[mem_address[15:0]];
        if (mem_write)
        begin
            mem[mem_address[15:0]] = mem_wdata;
            if (mem_address == LCD_CMD_ADDR || mem_address == LCD_DATA_ADDR)
                lcd_log.push_back(int'({mem_address == LCD_DATA_ADDR, mem_wdata}));
        end
        #DRIVE_DELAY;
        if (read_pending)
            mem_rdata = read_byte;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog: the run went past four frames without finishing");
        $display("Test failed");
        $finish;
    end

    task automatic after_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Bus grant high three cycles out of four on average
    task automatic drive_grant();
        forever
        begin
            after_edge();
            mem_grant = ($urandom_range(0, 3) != 0);
        end
    endtask

    task automatic write_reg(input logic [3:0] offset, input byte_t data);
        after_edge();
        reg_address = REG_BASE + addr_t'(offset);
        reg_wdata   = data;
        reg_write   = 1'b1;
        after_edge();
        reg_write   = 1'b0;
    endtask

    // Read data is taken just before the next edge
    task automatic read_addr(input addr_t address, output byte_t data);
        after_edge();
        reg_address = address;
        reg_read    = 1'b1;
        @(posedge clk);
        data = reg_rdata;
        #DRIVE_DELAY reg_read = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0)
        begin
            $display("[PASS] %s", test_name);
            pass_count++;
        end
        else
        begin
            $display("[FAIL] %s with %0d errors", test_name, test_errors);
            fail_count++;
        end
    endtask

    task automatic compare_value(input string what, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("** Error %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic require(input bit condition, input string complaint);
        assert (condition)
        else
        begin
            $display("%s: %s", test_name, complaint);
            test_errors++;
        end
    endtask

    // Map size in tiles from mode bits 5:4
    function automatic void map_size(input int size, output int w, output int h);
        case (size)
            0:
            begin
                w = 12;
                h = 16;
            end
            1:
            begin
                w = 16;
                h = 12;
            end
            2:
            begin
                w = 24;
                h = 8;
            end
            default:
            begin
                w = 24;
                h = 16;
            end
        endcase
    endfunction

    // One frame-buffer byte from two tile rows
    function automatic byte_t expected_column(input int x, input int y, input int w,
                                              input int sx, input int sy, input int base);
        int          mx;
        int          my;
        int          map_addr;
        int          top_idx;
        int          bot_idx;
        int          shift;
        byte_t       top_byte;
        byte_t       bot_byte;
        logic [15:0] merged;
        mx       = x + sx;
        my       = 8 * y + sy;
        map_addr = int'(TILE_MAP_BASE) + (my / 8) * w + mx / 8;
        top_idx  = int'(mem[map_addr]);
        bot_idx  = int'(mem[map_addr + w]);
        top_byte = mem[base + top_idx * 8 + mx % 8];
        bot_byte = mem[base + bot_idx * 8 + mx % 8];
        shift    = my % 8;
        merged   = ({8'h00, top_byte} >> shift) | ({8'h00, bot_byte} << (8 - shift));
        return merged[7:0];
    endfunction

    task automatic register_readback();
        int         i;
        int         sel;
        byte_t      data;
        byte_t      got;
        byte_t      expected;
        logic [3:0] offset;
        begin_test("register_readback");
        for (i = 0; i < 24; i++)
        begin
            sel  = $urandom_range(0, 3);
            data = 8'($urandom_range(0, 255));
            case (sel)
                0:
                begin
                    offset   = REG_MODE;
                    expected = data & 8'h3F;
                end
                1:
                begin
                    offset   = REG_MAP_LO;
                    expected = data & 8'hF8;     // 8-byte aligned tile base
                end
                2:
                begin
                    offset   = REG_MAP_MID;
                    expected = data;
                end
                default:
                begin
                    offset   = REG_MAP_HI;
                    expected = data & 8'h1F;
                end
            endcase
            write_reg(offset, data);
            read_addr(REG_BASE + addr_t'(offset), got);
            compare_value($sformatf("offset %0h", offset), int'(expected), int'(got));
        end
        write_reg(REG_RATE, 8'($urandom_range(1, 255)));
        read_addr(REG_BASE + addr_t'(REG_RATE), got);
        compare_value("rate register", 0, int'(got));
        for (i = 7; i < 16; i++)
        begin
            if (i != int'(REG_COUNTER))
            begin
                read_addr(REG_BASE + addr_t'(i), got);
                compare_value($sformatf("unused offset %0h", i), 0, int'(got));
            end
        end
        // Addresses just above the register block
        for (i = 0; i < 8; i++)
        begin
            read_addr(REG_BASE + addr_t'(16 + $urandom_range(0, 'h6F)), got);
            compare_value("address outside the block", 0, int'(got));
        end
        write_reg(REG_MODE, 8'h00);
        end_test();
    endtask

    task automatic scroll_clamping();
        int    i;
        int    w;
        int    h;
        int    limit;
        int    data;
        int    sx_model;
        int    sy_model;
        byte_t got;
        begin_test("scroll_clamping");
        sx_model = 0;
        sy_model = 0;
        for (i = 0; i < 32; i++)
        begin
            data = $urandom_range(0, 3);
            map_size(data, w, h);
            write_reg(REG_MODE, 8'(data << MODE_SIZE_LSB));
            if ($urandom_range(0, 1) == 1)
            begin
                limit = w * 8 - SCREEN_W;
                data  = $urandom_range(0, limit + 24);
                write_reg(REG_SCROLL_X, 8'(data));
                if (data <= limit)
                    sx_model = data;
                read_addr(REG_BASE + addr_t'(REG_SCROLL_X), got);
                compare_value("scroll X", sx_model, int'(got));
            end
            else
            begin
                limit = h * 8 - 64;
                data  = $urandom_range(0, limit + 24);
                write_reg(REG_SCROLL_Y, 8'(data));
                if (data <= limit)
                    sy_model = data;
                read_addr(REG_BASE + addr_t'(REG_SCROLL_Y), got);
                compare_value("scroll Y", sy_model, int'(got));
            end
        end
        write_reg(REG_MODE, 8'h00);
        end_test();
    endtask

    task automatic render_and_copy();
        int    size;
        int    w;
        int    h;
        int    sx;
        int    sy;
        int    base;
        int    n;
        int    p;
        int    x;
        int    k;
        byte_t lo;
        byte_t mid;
        byte_t mode_val;
        bit    irq_seen;
        int    expected_log [$];
        begin_test("map_render");
        size = $urandom_range(0, 3);
        map_size(size, w, h);
        sx   = $urandom_range(0, w * 8 - SCREEN_W);
        sy   = $urandom_range(0, h * 8 - 64);
        lo   = 8'($urandom_range(0, 255));
        mid  = 8'h40 + 8'($urandom_range(0, 'hB0));  // Tile data clear of the frame buffer
        mode_val = 8'(size << MODE_SIZE_LSB);
        write_reg(REG_MODE, mode_val);
        write_reg(REG_SCROLL_X, 8'(sx));
        write_reg(REG_SCROLL_Y, 8'(sy));
        write_reg(REG_MAP_LO, lo);
        write_reg(REG_MAP_MID, mid);
        write_reg(REG_MAP_HI, 8'h00);
        base = int'({mid, lo[7:3], 3'b000});
        for (k = 0; k < FB_BYTES; k++)
            exp_fb[k] = expected_column(k % SCREEN_W, k / SCREEN_W, w, sx, sy, base);
        lcd_log.delete();
        mode_val[MODE_MAP_BIT]  = 1'b1;
        mode_val[MODE_COPY_BIT] = 1'b1;
        write_reg(REG_MODE, mode_val);

        n = 0;
        while (!mem_request && n < FRAME_CYCLES + TICK_CYCLES)
        begin
            @(posedge clk);
            n++;
        end
        require(mem_request, "mem_request never rose after the window opened");
        n = 0;
        while (mem_request && n < FRAME_CYCLES)
        begin
            @(posedge clk);
            n++;
        end
        require(!mem_request, "map draw and frame copy did not finish within a frame");
        irq_seen = irq_copy_complete;
        write_reg(REG_MODE, 8'h00);

        for (k = 0; k < FB_BYTES; k++)
            compare_value($sformatf("frame buffer page %0d column %0d", k / SCREEN_W,
                          k % SCREEN_W), int'(exp_fb[k]), int'(mem[int'(FB_BASE) + k]));
        end_test();

        begin_test("frame_copy");
        compare_value("irq_copy_complete", 1, int'(irq_seen));
        for (p = 0; p < SCREEN_PAGES; p++)
        begin
            expected_log.push_back(int'(LCD_COL_HI_CMD));
            expected_log.push_back(int'(LCD_COL_LO_CMD));
            expected_log.push_back(int'(LCD_PAGE_CMD) | p);
            for (x = 0; x < SCREEN_W; x++)
                expected_log.push_back(256 | int'(mem[int'(FB_BASE) + p * SCREEN_W + x]));
        end
        compare_value("LCD write count", expected_log.size(), lcd_log.size());
        for (k = 0; k < expected_log.size() && k < lcd_log.size(); k++)
            compare_value($sformatf("LCD write %0d", k), expected_log[k], lcd_log[k]);
        end_test();
    endtask

    task automatic frame_counter_sweep();
        int n;
        int count;
        int prev;
        int rises;
        int changes;
        int bad_range;
        int bad_order;
        bit prev_irq;
        begin_test("frame_counter");
        rises     = 0;
        changes   = 0;
        bad_range = 0;
        bad_order = 0;
        after_edge();
        reg_address = REG_BASE + addr_t'(REG_COUNTER);
        reg_read    = 1'b1;
        @(posedge clk);
        prev     = int'(reg_rdata);
        prev_irq = irq_render_done;
        for (n = 0; n < FRAME_CYCLES; n++)
        begin
            @(posedge clk);
            count = int'(reg_rdata);
            if (count < 1 || count > 'h41)
                bad_range++;
            if (count != prev)
            begin
                changes++;
                if (!(count == prev + 1 || (prev == 'h41 && count == 1)))
                    bad_order++;             // Only a wrap may go down
            end
            if (irq_render_done && !prev_irq)
                rises++;
            prev     = count;
            prev_irq = irq_render_done;
        end
        #DRIVE_DELAY reg_read = 1'b0;
        compare_value("counter reads out of range", 0, bad_range);
        compare_value("counter steps out of order", 0, bad_order);
        compare_value("counter steps per frame", 65, changes);
        compare_value("irq_render_done rises per frame", 1, rises);
        end_test();
    endtask

    task automatic idle_frame();
        int n;
        int busy_cycles;
        begin_test("idle_mode");
        busy_cycles = 0;
        write_reg(REG_MODE, 8'h00);
        for (n = 0; n < FRAME_CYCLES; n++)
        begin
            @(posedge clk);
            if (mem_request || mem_read || mem_write)
                busy_cycles++;
        end
        compare_value("cycles with bus activity", 0, busy_cycles);
        end_test();
    endtask

    initial
    begin
        int i;
        void'($urandom(SEED));
        reset       = 1'b1;
        reg_address = '0;
        reg_wdata   = '0;
        reg_write   = 1'b0;
        reg_read    = 1'b0;
        mem_rdata   = '0;
        mem_grant   = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        for (i = 0; i < 65536; i++)
            mem[i] = 8'($urandom_range(0, 255));
        fork
            drive_grant();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY reset = 1'b0;

        register_readback();
        scroll_clamping();
        render_and_copy();       // Runs in the first frame window
        frame_counter_sweep();
        idle_frame();

        $display("Summary: %0d passed, %0d with errors", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
